// File: fifo.sv
module fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           we,
    input  scene_pkg::pixel_buffer_entry_t data_in,
    input  logic                           re,
    output scene_pkg::pixel_buffer_entry_t data_out,
    output logic                           full,
    output logic                           empty,
    output scene_pkg::pb_cnt_t             free
);

    scene_pkg::pixel_buffer_entry_t mem [scene_pkg::PB_DEPTH];
    scene_pkg::pb_ptr_t wr_ptr;
    scene_pkg::pb_ptr_t rd_ptr;
    scene_pkg::pb_cnt_t count;
    logic do_wr;
    logic do_rd;

    assign do_wr = we && !full;
    assign do_rd = re && !empty;
    assign full = (count == scene_pkg::pb_cnt_t'(scene_pkg::PB_DEPTH));
    assign empty = (count == '0);
    assign free = scene_pkg::pb_cnt_t'(scene_pkg::PB_DEPTH) - count;

    // Show-ahead head entry
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: frame_buffer_handler.sv
module frame_buffer_handler (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic                                                          stripes_sel,
    input  logic [scene_pkg::NUM_RETRIEVERS-1:0]                          pb_empty,
    input  scene_pkg::pixel_buffer_entry_t [scene_pkg::NUM_RETRIEVERS-1:0] pb_data,
    output logic [scene_pkg::NUM_RETRIEVERS-1:0]                          pb_re,
    input  logic [scene_pkg::NUM_RETRIEVERS-1:0]                          ret_done,
    output logic                                                          fb_we,
    output scene_pkg::addr_t                                              fb_addr,
    output logic [23:0]                                                   fb_color,
    output logic                                                          frame_done
);

    scene_pkg::handler_state_t state;
    scene_pkg::rid_t last;
    logic [scene_pkg::RID_W:0] pick;
    scene_pkg::rid_t pick_idx;
    scene_pkg::pixel_buffer_entry_t head;
    logic all_idle;

    assign pick = scene_pkg::rr_pick(~pb_empty, last);
    assign pick_idx = pick[scene_pkg::RID_W-1:0];
    assign head = pb_data[pick_idx];

    // Nothing left anywhere and the last write already out
    assign all_idle = (&ret_done) && (&pb_empty) && !fb_we;

    always_comb begin
        pb_re = '0;
        pb_re[pick_idx] = pick[scene_pkg::RID_W];
    end

    // Stripe mask blanks pixels with index bit 2 set
    always_ff @(posedge clk) begin
        fb_addr <= head.index;
        fb_color <= (stripes_sel && head.index[2]) ? 24'h0 : head.color;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= scene_pkg::H_RUN;
            last <= '0;
            fb_we <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            fb_we <= pick[scene_pkg::RID_W];
            if (pick[scene_pkg::RID_W]) begin
                last <= pick_idx;
            end
            frame_done <= 1'b0;
            if (state == scene_pkg::H_RUN && all_idle) begin
                frame_done <= 1'b1;
                state <= scene_pkg::H_FINISHED;
            end
        end
    end

endmodule

// File: memory_request_arbiter.sv
module memory_request_arbiter (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 write_req,
    input  scene_pkg::addr_t                                     write_addr,
    input  logic [31:0]                                          write_data,
    input  logic [scene_pkg::NUM_RETRIEVERS-1:0]                 read_req,
    input  scene_pkg::addr_t [scene_pkg::NUM_RETRIEVERS-1:0]     read_addr,
    input  scene_pkg::trans_t [scene_pkg::NUM_RETRIEVERS-1:0]    read_size,
    output logic [scene_pkg::NUM_RETRIEVERS-1:0]                 read_valid,
    output logic [scene_pkg::NUM_RETRIEVERS-1:0]                 read_done,
    output logic [31:0]                                          read_data,
    output logic                                                 ram_we,
    output scene_pkg::addr_t                                     ram_addr,
    output logic [31:0]                                          ram_wdata,
    input  logic [31:0]                                          ram_rdata
);

    logic busy;
    scene_pkg::rid_t owner;
    scene_pkg::addr_t burst_addr;
    scene_pkg::trans_t remaining;
    logic issue;
    logic [scene_pkg::RID_W:0] pick;
    scene_pkg::rid_t pick_idx;

    // Return stage, tags RAM data with its owner
    logic pipe_valid;
    logic pipe_last;
    scene_pkg::rid_t pipe_owner;

    assign pick = scene_pkg::rr_pick(read_req, owner);
    assign pick_idx = pick[scene_pkg::RID_W-1:0];

    // Loader writes always win the RAM port
    assign issue = busy && !write_req;
    assign ram_we = write_req;
    assign ram_addr = write_req ? write_addr : burst_addr;
    assign ram_wdata = write_data;
    assign read_data = ram_rdata;

    always_comb begin
        read_valid = '0;
        read_done = '0;
        read_valid[pipe_owner] = pipe_valid;
        read_done[pipe_owner] = pipe_valid && pipe_last;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            owner <= '0;
            burst_addr <= '0;
            remaining <= '0;
            pipe_valid <= 1'b0;
            pipe_last <= 1'b0;
            pipe_owner <= '0;
        end else begin
            pipe_valid <= issue;
            pipe_last <= issue && (remaining == scene_pkg::trans_t'(1));
            pipe_owner <= owner;
            if (issue) begin
                burst_addr <= burst_addr + 1'b1;
                remaining <= remaining - 1'b1;
                if (remaining == scene_pkg::trans_t'(1)) begin
                    busy <= 1'b0;
                end
            end else if (!busy && !write_req && !pipe_valid && pick[scene_pkg::RID_W]) begin
                // Wait for the done pulse to drain so the old owner drops its request
                busy <= 1'b1;
                owner <= pick_idx;
                burst_addr <= read_addr[pick_idx];
                remaining <= read_size[pick_idx];
            end
        end
    end

endmodule

// File: scene_loader.sv
module scene_loader (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              byte_valid,
    input  logic [7:0]        byte_data,
    output logic              write_req,
    output scene_pkg::addr_t  write_addr,
    output logic [31:0]       write_data,
    output logic              scene_loaded
);

    logic [1:0] lane;
    logic accept;

    // One scene per reset
    assign accept = byte_valid && !scene_loaded;

    // Little-endian packing, first byte ends up in bits 7:0
    always_ff @(posedge clk) begin
        if (accept) begin
            write_data <= {byte_data, write_data[31:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane <= '0;
            write_req <= 1'b0;
            write_addr <= '0;
            scene_loaded <= 1'b0;
        end else begin
            write_req <= accept && (lane == 2'd3);
            if (accept) begin
                lane <= lane + 2'd1;
            end
            if (write_req) begin
                write_addr <= write_addr + 1'b1;
                if (write_addr == scene_pkg::addr_t'(scene_pkg::SCENE_WORDS - 1)) begin
                    scene_loaded <= 1'b1;
                end
            end
        end
    end

endmodule

// File: scene_pkg.sv
package scene_pkg;

    // Scene geometry
    localparam logic [31:0] SCENE_WORDS = 32'd64;
    localparam int ADDR_W = 6;
    localparam int NUM_RETRIEVERS = 4;
    localparam int SLICE_WORDS = SCENE_WORDS / NUM_RETRIEVERS;
    localparam int RID_W = $clog2(NUM_RETRIEVERS);

    // Bursts and pixel buffers
    localparam int MAX_TRANS = 8;
    localparam int TRANS_W = 4;
    localparam int PB_DEPTH = 16;
    localparam int PB_CNT_W = 5;
    localparam int PB_PTR_W = $clog2(PB_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TRANS_W-1:0] trans_t;
    typedef logic [RID_W-1:0] rid_t;
    typedef logic [PB_CNT_W-1:0] pb_cnt_t;
    typedef logic [PB_PTR_W-1:0] pb_ptr_t;

    // Held in scene word bits 31:30
    typedef enum logic [1:0] {
        OP_PASS,
        OP_INVERT,
        OP_SWAP,
        OP_SKIP
    } scene_op_t;

    typedef struct packed {
        addr_t index;
        logic [23:0] color;
    } pixel_buffer_entry_t;

    typedef enum logic [1:0] {
        R_IDLE,
        R_WAIT_ROOM,
        R_READ,
        R_DONE
    } retriever_state_t;

    typedef enum logic {
        H_RUN,
        H_FINISHED
    } handler_state_t;

    // Round-robin pick starting after last; MSB flags a hit
    function automatic logic [RID_W:0] rr_pick(
        input logic [NUM_RETRIEVERS-1:0] req,
        input rid_t last
    );
        logic [RID_W:0] pick;
        rid_t idx;
        pick = '0;
        for (int i = NUM_RETRIEVERS; i >= 1; i--) begin
            idx = rid_t'((int'(last) + i) % NUM_RETRIEVERS);
            if (req[idx]) begin
                pick = {1'b1, idx};
            end
        end
        return pick;
    endfunction

endpackage

// File: scene_properties.sv
module scene_properties (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic [scene_pkg::NUM_RETRIEVERS-1:0] read_req,
    input logic [scene_pkg::NUM_RETRIEVERS-1:0] read_valid,
    input logic [scene_pkg::NUM_RETRIEVERS-1:0] read_done,
    input logic                                 ram_we,
    input logic                                 busy
);

    int error_count = 0;

    // Words of one burst all go to the same retriever
    a_burst_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (|read_valid && !(|read_done)) |=> ((read_valid & ~$past(read_valid)) == '0))
    else begin
        error_count++;
        $error("read_valid moved to another retriever before read_done");
    end

    a_valid_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (read_valid & ~read_req) == '0)
    else begin
        error_count++;
        $error("read_valid went to a retriever that has no request");
    end

    // Loading ends before the first burst starts
    a_port_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(ram_we && busy))
    else begin
        error_count++;
        $error("RAM write while a burst read is in progress");
    end

endmodule

bind memory_request_arbiter scene_properties i_props (
    .clk, .rst_n, .read_req, .read_valid, .read_done, .ram_we, .busy
);

// File: scene_ram.sv
module scene_ram (
    input  logic              clk,
    input  logic              we,
    input  scene_pkg::addr_t  addr,
    input  logic [31:0]       wdata,
    output logic [31:0]       rdata
);

    logic [31:0] mem [scene_pkg::SCENE_WORDS];

    // Registered read, data valid the cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: scene_retriever.sv
module scene_retriever #(
    parameter int RETRIEVER_ID = 0
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           scene_loaded,
    output logic                           read_req,
    output scene_pkg::addr_t               read_addr,
    output scene_pkg::trans_t              read_size,
    input  logic                           read_valid,
    input  logic                           read_done,
    input  logic [31:0]                    read_data,
    output logic                           pb_we,
    output scene_pkg::pixel_buffer_entry_t pb_data,
    input  scene_pkg::pb_cnt_t             pb_free,
    output logic                           ret_done
);

    scene_pkg::retriever_state_t state;
    scene_pkg::addr_t slice_base;
    scene_pkg::addr_t last_burst;
    scene_pkg::addr_t burst_addr;
    scene_pkg::addr_t pix_idx;
    scene_pkg::scene_op_t op;
    logic [23:0] color;
    logic [23:0] shaded;

    assign slice_base = scene_pkg::addr_t'(RETRIEVER_ID * scene_pkg::SLICE_WORDS);
    assign last_burst = slice_base
                      + scene_pkg::addr_t'(scene_pkg::SLICE_WORDS - scene_pkg::MAX_TRANS);
    assign read_addr = burst_addr;
    assign read_size = scene_pkg::trans_t'(scene_pkg::MAX_TRANS);

    assign op = scene_pkg::scene_op_t'(read_data[31:30]);
    assign color = read_data[23:0];

    always_comb begin
        case (op)
            scene_pkg::OP_INVERT: shaded = ~color;
            scene_pkg::OP_SWAP:   shaded = {color[7:0], color[15:8], color[23:16]};
            default:              shaded = color;
        endcase
    end

    always_ff @(posedge clk) begin
        pb_data.index <= pix_idx;
        pb_data.color <= shaded;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= scene_pkg::R_IDLE;
            read_req <= 1'b0;
            burst_addr <= slice_base;
            pix_idx <= slice_base;
            pb_we <= 1'b0;
            ret_done <= 1'b0;
        end else begin
            pb_we <= read_valid && (op != scene_pkg::OP_SKIP);
            if (read_valid) begin
                pix_idx <= pix_idx + 1'b1;
            end
            case (state)
                scene_pkg::R_IDLE: begin
                    if (scene_loaded) begin
                        state <= scene_pkg::R_WAIT_ROOM;
                    end
                end
                scene_pkg::R_WAIT_ROOM: begin
                    // Free count lags a write in flight by one cycle
                    if (!pb_we && pb_free >= scene_pkg::MAX_TRANS) begin
                        read_req <= 1'b1;
                        state <= scene_pkg::R_READ;
                    end
                end
                scene_pkg::R_READ: begin
                    if (read_done) begin
                        read_req <= 1'b0;
                        if (burst_addr == last_burst) begin
                            state <= scene_pkg::R_DONE;
                        end else begin
                            burst_addr <= burst_addr + scene_pkg::addr_t'(scene_pkg::MAX_TRANS);
                            state <= scene_pkg::R_WAIT_ROOM;
                        end
                    end
                end
                scene_pkg::R_DONE: begin
                    ret_done <= 1'b1;
                end
                default: state <= scene_pkg::R_IDLE;
            endcase
        end
    end

endmodule

// File: scene_top.sv
module scene_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              byte_valid,
    input  logic [7:0]        byte_data,
    input  logic              stripes_sel,
    output logic              fb_we,
    output scene_pkg::addr_t  fb_addr,
    output logic [23:0]       fb_color,
    output logic              frame_done,
    output logic              scene_loaded
);

    // Loader to arbiter
    logic write_req;
    scene_pkg::addr_t write_addr;
    logic [31:0] write_data;

    // Retriever read side
    logic [scene_pkg::NUM_RETRIEVERS-1:0] read_req;
    scene_pkg::addr_t [scene_pkg::NUM_RETRIEVERS-1:0] read_addr;
    scene_pkg::trans_t [scene_pkg::NUM_RETRIEVERS-1:0] read_size;
    logic [scene_pkg::NUM_RETRIEVERS-1:0] read_valid;
    logic [scene_pkg::NUM_RETRIEVERS-1:0] read_done;
    logic [31:0] read_data;

    // RAM port
    logic ram_we;
    scene_pkg::addr_t ram_addr;
    logic [31:0] ram_wdata;
    logic [31:0] ram_rdata;

    // Pixel buffers
    logic [scene_pkg::NUM_RETRIEVERS-1:0] pb_we;
    scene_pkg::pixel_buffer_entry_t [scene_pkg::NUM_RETRIEVERS-1:0] pb_in;
    logic [scene_pkg::NUM_RETRIEVERS-1:0] pb_re;
    scene_pkg::pixel_buffer_entry_t [scene_pkg::NUM_RETRIEVERS-1:0] pb_out;
    logic [scene_pkg::NUM_RETRIEVERS-1:0] pb_empty;
    scene_pkg::pb_cnt_t [scene_pkg::NUM_RETRIEVERS-1:0] pb_free;
    logic [scene_pkg::NUM_RETRIEVERS-1:0] ret_done;

    scene_loader i_loader (
        .clk, .rst_n, .byte_valid, .byte_data,
        .write_req, .write_addr, .write_data, .scene_loaded
    );

    memory_request_arbiter i_arbiter (
        .clk, .rst_n, .write_req, .write_addr, .write_data,
        .read_req, .read_addr, .read_size, .read_valid, .read_done, .read_data,
        .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    scene_ram i_ram (
        .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    for (genvar k = 0; k < scene_pkg::NUM_RETRIEVERS; k++) begin : g_ret
        scene_retriever #(.RETRIEVER_ID(k)) i_retriever (
            .clk, .rst_n, .scene_loaded,
            .read_req(read_req[k]), .read_addr(read_addr[k]), .read_size(read_size[k]),
            .read_valid(read_valid[k]), .read_done(read_done[k]), .read_data,
            .pb_we(pb_we[k]), .pb_data(pb_in[k]), .pb_free(pb_free[k]),
            .ret_done(ret_done[k])
        );

        fifo i_fifo (
            .clk, .rst_n, .we(pb_we[k]), .data_in(pb_in[k]), .re(pb_re[k]),
            .data_out(pb_out[k]), .full(), .empty(pb_empty[k]), .free(pb_free[k])
        );
    end

    frame_buffer_handler i_handler (
        .clk, .rst_n, .stripes_sel, .pb_empty, .pb_data(pb_out), .pb_re, .ret_done,
        .fb_we, .fb_addr, .fb_color, .frame_done
    );

endmodule

// File: tb.f
scene_pkg.sv
scene_loader.sv
scene_ram.sv
memory_request_arbiter.sv
scene_retriever.sv
fifo.sv
frame_buffer_handler.sv
scene_top.sv
scene_properties.sv
tb_scene_top.sv

// File: tb_scene_top.sv
module tb_scene_top;

    localparam int PERIOD = 100;
    localparam int WORDS = int'(scene_pkg::SCENE_WORDS);
    localparam int SW = scene_pkg::SLICE_WORDS;
    localparam int LOAD_CYCLES = WORDS * 4 + 16;
    localparam int FRAME_CYCLES = WORDS * 8;
    localparam int RUN_CYCLES = 3 + LOAD_CYCLES + FRAME_CYCLES + 24;
    localparam int WATCHDOG = 6 * RUN_CYCLES * PERIOD;

    logic clk = 1'b0;
    logic rst_n;
    logic byte_valid;
    logic [7:0] byte_data;
    logic stripes_sel;
    logic fb_we;
    scene_pkg::addr_t fb_addr;
    logic [23:0] fb_color;
    logic frame_done;
    logic scene_loaded;

    // Scoreboard
    logic [31:0] scene [WORDS];
    logic [23:0] exp_color [WORDS];
    bit exp_skip [WORDS];
    int next_idx [scene_pkg::NUM_RETRIEVERS];
    int write_cnt;
    int done_cnt;
    int seed = 95;

    scene_top i_dut (
        .clk, .rst_n, .byte_valid, .byte_data, .stripes_sel,
        .fb_we, .fb_addr, .fb_color, .frame_done, .scene_loaded
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_color(input string name, input logic [23:0] got,
                               input logic [23:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s = 0x%06h, expected 0x%06h", name, got, exp));
        end
    endtask

    task automatic check_index(input string name, input scene_pkg::addr_t got,
                               input scene_pkg::addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
        end
    endtask

    function automatic logic [23:0] shade(input logic [31:0] word);
        logic [23:0] c;
        c = word[23:0];
        case (scene_pkg::scene_op_t'(word[31:30]))
            scene_pkg::OP_INVERT: return ~c;
            scene_pkg::OP_SWAP:   return {c[7:0], c[15:8], c[23:16]};
            default:              return c;
        endcase
    endfunction

    // First written pixel of slice k at or after from
    function automatic int next_pixel(input int from, input int k);
        int i;
        i = from;
        while (i < (k + 1) * SW && exp_skip[i]) begin
            i++;
        end
        return i;
    endfunction

    function automatic logic [23:0] pixel_color(input int i);
        return (stripes_sel && i[2]) ? 24'h0 : exp_color[i];
    endfunction

    // Each slice leaves its FIFO in address order
    always @(negedge clk) begin
        int k;
        if (i_dut.i_arbiter.i_props.error_count != 0) begin
            fail_run("an arbiter assertion failed");
        end
        if (rst_n === 1'b1) begin
            if (fb_we) begin
                if (!scene_loaded) begin
                    fail_run("fb_we was high before the scene was loaded");
                end
                if (done_cnt != 0) begin
                    fail_run("fb_we came after frame_done");
                end
                k = int'(fb_addr) / SW;
                if (next_idx[k] >= (k + 1) * SW) begin
                    fail_run($sformatf("slice %0d wrote more pixels than expected", k));
                end
                check_index("fb_addr", fb_addr, scene_pkg::addr_t'(next_idx[k]));
                check_color("fb_color", fb_color, pixel_color(next_idx[k]));
                next_idx[k] = next_pixel(next_idx[k] + 1, k);
                write_cnt++;
            end
            if (frame_done) begin
                done_cnt++;
            end
        end
    end

    initial begin
        #(WATCHDOG);
        fail_run("watchdog expired before all tests finished");
    end

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        byte_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        write_cnt = 0;
        done_cnt = 0;
    endtask

    task automatic build_scene(input bit mixed);
        logic [31:0] word;
        for (int i = 0; i < WORDS; i++) begin
            word = $random(seed);
            if (!mixed) begin
                word[31:30] = scene_pkg::OP_PASS;
            end
            scene[i] = word;
            exp_skip[i] = (scene_pkg::scene_op_t'(word[31:30]) == scene_pkg::OP_SKIP);
            exp_color[i] = shade(word);
        end
        for (int k = 0; k < scene_pkg::NUM_RETRIEVERS; k++) begin
            next_idx[k] = next_pixel(k * SW, k);
        end
    endtask

    // Four bytes per word with the lowest byte first
    task automatic stream_scene();
        for (int i = 0; i < WORDS; i++) begin
            for (int b = 0; b < 4; b++) begin
                @(posedge clk);
                byte_valid <= 1'b1;
                byte_data <= scene[i][8*b +: 8];
            end
        end
        @(posedge clk);
        byte_valid <= 1'b0;
    endtask

    task automatic await_loaded();
        int n;
        n = 0;
        @(negedge clk);
        while (!scene_loaded) begin
            n++;
            if (n > 8) begin
                fail_run("scene_loaded did not rise after the last word");
            end
            @(negedge clk);
        end
    endtask

    task automatic await_frame();
        int n;
        n = 0;
        while (done_cnt == 0) begin
            n++;
            if (n > FRAME_CYCLES) begin
                fail_run("frame_done did not arrive in time");
            end
            @(negedge clk);
        end
    endtask

    task automatic verify_frame();
        int expected;
        expected = 0;
        repeat (16) @(negedge clk);
        if (done_cnt != 1) begin
            fail_run($sformatf("frame_done pulsed %0d times instead of once", done_cnt));
        end
        for (int i = 0; i < WORDS; i++) begin
            expected += exp_skip[i] ? 0 : 1;
        end
        for (int k = 0; k < scene_pkg::NUM_RETRIEVERS; k++) begin
            if (next_idx[k] != (k + 1) * SW) begin
                fail_run($sformatf("pixel %0d was never written", next_idx[k]));
            end
        end
        if (write_cnt != expected) begin
            fail_run($sformatf("%0d pixels written instead of %0d", write_cnt, expected));
        end
    endtask

    task automatic run_frame(input bit mixed, input bit stripes);
        apply_reset();
        stripes_sel <= stripes;
        build_scene(mixed);
        stream_scene();
        await_loaded();
        await_frame();
        verify_frame();
    endtask

    task automatic load_scene();
        apply_reset();
        build_scene(1'b1);
        stream_scene();
        @(negedge clk);
        if (scene_loaded) begin
            fail_run("scene_loaded rose before the last word was written");
        end
        await_loaded();
    endtask

    task automatic render_pass_only();
        run_frame(1'b0, 1'b0);
    endtask

    task automatic render_opcodes();
        run_frame(1'b1, 1'b0);
    endtask

    task automatic render_stripes();
        run_frame(1'b1, 1'b1);
        stripes_sel <= 1'b0;
    endtask

    task automatic reset_midframe();
        int n;
        n = 0;
        apply_reset();
        build_scene(1'b0);
        stream_scene();
        await_loaded();
        while (write_cnt < 8) begin
            n++;
            if (n > FRAME_CYCLES) begin
                fail_run("rendering did not start before the reset");
            end
            @(negedge clk);
        end
        apply_reset();
        repeat (4) begin
            @(negedge clk);
            if (fb_we || frame_done) begin
                fail_run("fb_we or frame_done high after the reset");
            end
        end
        render_pass_only();
    endtask

    initial begin
        rst_n = 1'b0;
        byte_valid = 1'b0;
        byte_data = 8'h0;
        stripes_sel = 1'b0;
        load_scene();
        render_pass_only();
        render_opcodes();
        render_stripes();
        reset_midframe();
        if (i_dut.i_arbiter.i_props.error_count != 0) begin
            fail_run("an arbiter assertion failed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
